// File: oled_testdata.txt
# op arg nframes, then per frame: bytes dc first_byte sum16 (all hex except counts)
# update fills all 64 characters with the argument code
poweron 01 2 1 0 ae 00ae 2 0 20 0021
contrast 7f 0
contrast 40 1 2 0 81 00c1
disp 00 1 1 0 af 00af
update 00 1 512 1 00 0000
update 10 1 512 1 00 cf00
update 21 1 512 1 40 8780
update 30 1 512 1 00 0000
disp 01 1 1 0 ae 00ae
contrast 40 0
disp 00 1 1 0 af 00af
poweroff 00 1 1 0 ae 00ae

// File: list.f
+incdir+.
oled_ctrl_pkg.sv
oled_font_pkg.sv
glyph_column.sv
spi_byte_tx.sv
oled_sequencer.sv
oled_top.sv
oled_checker.sv
tb_oled.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_oled
BUILD     ?= obj_dir
FLAGS     ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) -f list.f --top-module $(TOP) --Mdir $(BUILD)
	out=$$(./$(BUILD)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf $(BUILD)

// File: tb_oled.sv
// OLED display testbench
// Clock, reset, test file reader, stimulus driver and watchdog

`timescale 1ns/1ps
`include "oled_defines.svh"

module tb_oled;

  localparam int DELAY = `OLED_POWER_DELAY;

  logic         clk = 1'b0;
  logic         rst;
  logic         power_on, display_off, update;
  logic [7:0]   contrast;
  logic [511:0] display_data;
  logic         cs, sck, mosi, dc, vdd_c, vbat_c;

  logic [95:0]  t_op [32];
  logic [7:0]   t_arg [32];
  int           t_nf [32];
  int           t_cnt [32][2];
  logic [7:0]   t_dc [32][2];
  logic [7:0]   t_first [32][2];
  logic [15:0]  t_sum [32][2];
  int           n_tests;
  int           limit_cycles;
  logic         limit_ready = 1'b0;

  always #50 clk = ~clk;

  oled_top dut (
    .clk(clk), .rst(rst), .power_on(power_on), .display_off(display_off),
    .update(update), .contrast(contrast), .display_data(display_data),
    .cs(cs), .sck(sck), .mosi(mosi), .dc(dc), .vdd_c(vdd_c), .vbat_c(vbat_c)
  );

  oled_checker chk (
    .cs(cs), .sck(sck), .mosi(mosi), .dc(dc), .vdd_c(vdd_c), .vbat_c(vbat_c)
  );

  task automatic load_tests();
    int    fd;
    int    rc;
    string line;
    begin
      n_tests = 0;
      fd = $fopen("oled_testdata.txt", "r");
      if (fd == 0)
        $display("could not open oled_testdata.txt");
      while (fd != 0 && !$feof(fd) && n_tests < 32)
      begin
        rc = $fgets(line, fd);
        if (rc > 1 && line[0] != "#")
        begin
          rc = $sscanf(line, "%s %h %d %d %h %h %h %d %h %h %h", t_op[n_tests],
                       t_arg[n_tests], t_nf[n_tests], t_cnt[n_tests][0], t_dc[n_tests][0],
                       t_first[n_tests][0], t_sum[n_tests][0], t_cnt[n_tests][1],
                       t_dc[n_tests][1], t_first[n_tests][1], t_sum[n_tests][1]);
          if (rc >= 3)
            n_tests++;
        end
      end
      if (fd != 0)
        $fclose(fd);
    end
  endtask

  task automatic run_test(input int i);
    int gap;
    begin
      gap = $urandom % 8;
      chk.begin_test(t_op[i], t_nf[i]);
      for (int k = 0; k < t_nf[i] && k < 2; k++)
        chk.set_frame(k, t_cnt[i][k], t_dc[i][k][0], t_first[i][k], t_sum[i][k]);
      @(negedge clk);
      if (t_op[i] == "poweron")
        power_on = 1'b1;
      else if (t_op[i] == "poweroff")
        power_on = 1'b0;
      else if (t_op[i] == "disp")
        display_off = t_arg[i][0];
      else if (t_op[i] == "contrast")
        contrast = t_arg[i];
      else if (t_op[i] == "update")
      begin
        for (int c = 0; c < 64; c++)
          display_data[c*8 +: 8] = t_arg[i];
        update = 1'b1; // One-cycle request
        @(negedge clk);
        update = 1'b0;
      end
      wait (chk.frames_seen >= t_nf[i]);
      repeat (DELAY / 2) @(negedge clk);
      if (t_op[i] == "poweron")
        chk.expect_pins(1'b0, 1'b1); // VBAT still off during the wait
      if (t_op[i] == "poweroff")
        chk.expect_pins(1'b0, 1'b0); // Both supplies held through the wait
      repeat (2 * DELAY + 8 + gap) @(negedge clk);
      if (t_op[i] == "poweron")
        chk.expect_pins(1'b0, 1'b0);
      if (t_op[i] == "poweroff")
        chk.expect_pins(1'b1, 1'b1);
      chk.end_test();
    end
  endtask

  initial
  begin
    void'($urandom(32'h4e6e));
    rst          = 1'b1;
    power_on     = 1'b0;
    display_off  = 1'b1;
    update       = 1'b0;
    contrast     = 8'h7f;
    display_data = '0;
    load_tests();
    limit_cycles = 2000;
    for (int i = 0; i < n_tests; i++)
      limit_cycles += (t_cnt[i][0] + t_cnt[i][1]) * 16 * `OLED_SCK_HALF * 2 + 4 * DELAY + 40;
    limit_ready = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    chk.begin_test("reset", 0);
    chk.expect_bus_idle();
    chk.expect_pins(1'b1, 1'b1);
    chk.end_test();
    for (int i = 0; i < n_tests; i++)
      run_test(i);
    $display("tests run %0d, passed %0d, failed %0d",
             chk.pass_count + chk.fail_count, chk.pass_count, chk.fail_count);
    if (chk.fail_count == 0 && n_tests > 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  // Watchdog sized from the expected traffic
  initial
  begin
    wait (limit_ready);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout after %0d cycles, the DUT stopped sending", limit_cycles);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: oled_checker.sv
// SPI monitor for the OLED testbench
// Decodes bytes and frames from the bus and compares them with expected frames

`timescale 1ns/1ps

module oled_checker (
  input logic cs,
  input logic sck,
  input logic mosi,
  input logic dc,
  input logic vdd_c,
  input logic vbat_c
);

  int          n_exp;
  int          frames_seen;
  int          test_errs;
  int          pass_count;
  int          fail_count;
  int          exp_cnt [2];
  logic        exp_dc [2];
  logic [7:0]  exp_first [2];
  logic [15:0] exp_sum [2];
  logic [95:0] test_name;
  logic [7:0]  shreg;
  int          nbits;
  int          nbytes;
  logic [7:0]  first_q;
  logic [15:0] sum_q;
  logic        dc_bad;
  logic        dc_got;
  logic        in_frame = 1'b0;

  task automatic begin_test(input logic [95:0] name, input int n);
    test_name   = name;
    n_exp       = n;
    frames_seen = 0;
    test_errs   = 0;
  endtask

  task automatic set_frame(input int k, input int cnt, input logic d,
                           input logic [7:0] first, input logic [15:0] sum);
    exp_cnt[k]   = cnt;
    exp_dc[k]    = d;
    exp_first[k] = first;
    exp_sum[k]   = sum;
  endtask

  task automatic expect_pins(input logic vdd_exp, input logic vbat_exp);
    if (vdd_c !== vdd_exp)
    begin
      $display("mismatch vdd_c exp %h got %h", vdd_exp, vdd_c);
      test_errs++;
    end
    if (vbat_c !== vbat_exp)
    begin
      $display("mismatch vbat_c exp %h got %h", vbat_exp, vbat_c);
      test_errs++;
    end
  endtask

  task automatic expect_bus_idle();
    if (cs !== 1'b1 || sck !== 1'b1)
    begin
      $display("mismatch cs/sck exp 1/1 got %h/%h", cs, sck);
      test_errs++;
    end
  endtask

  task automatic end_test();
    if (frames_seen != n_exp)
    begin
      $display("test %0s saw %0d frames where %0d were expected", test_name, frames_seen, n_exp);
      test_errs++;
    end
    if (test_errs == 0)
    begin
      $display("test %0s ok", test_name);
      pass_count++;
    end
    else
    begin
      $display("test %0s failed with %0d errors", test_name, test_errs);
      fail_count++;
    end
  endtask

  always @(negedge cs)
  begin
    in_frame = 1'b1;
    nbits    = 0;
    nbytes   = 0;
    sum_q    = '0;
    dc_bad   = 1'b0;
  end

  // Receiver samples on rising SCK
  always @(posedge sck)
  begin
    if (!cs)
    begin
      shreg = {shreg[6:0], mosi};
      nbits++;
      if (nbits == 8)
      begin
        nbits = 0;
        if (nbytes == 0)
          first_q = shreg;
        sum_q = sum_q + {8'h00, shreg};
        if (frames_seen < n_exp && dc !== exp_dc[frames_seen])
        begin
          dc_bad = 1'b1;
          dc_got = dc;
        end
        nbytes++;
      end
    end
  end

  always @(posedge cs)
  begin
    if (in_frame)
    begin
      in_frame = 1'b0;
      if (frames_seen >= n_exp)
      begin
        $display("unexpected extra frame of %0d bytes", nbytes);
        test_errs++;
      end
      else
      begin
        if (nbytes != exp_cnt[frames_seen])
        begin
          $display("mismatch byte_count exp %h got %h", exp_cnt[frames_seen], nbytes);
          test_errs++;
        end
        if (dc_bad)
        begin
          $display("mismatch dc exp %h got %h", exp_dc[frames_seen], dc_got);
          test_errs++;
        end
        if (first_q !== exp_first[frames_seen])
        begin
          $display("mismatch mosi first byte exp %h got %h", exp_first[frames_seen], first_q);
          test_errs++;
        end
        if (sum_q !== exp_sum[frames_seen])
        begin
          $display("mismatch mosi byte sum exp %h got %h", exp_sum[frames_seen], sum_q);
          test_errs++;
        end
      end
      frames_seen++;
    end
  end

endmodule

// File: oled_top.sv
// Pmod OLED text display top level
// Sequencer, glyph lookup and SPI serializer

`timescale 1ns/1ps
`include "oled_defines.svh"

module oled_top (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                                          power_on,
  input  logic                                          display_off,
  input  logic                                          update,
  input  oled_ctrl_pkg::cmd_byte_t                      contrast,
  input  logic [`OLED_CHARS_PER_LINE*`OLED_LINES*8-1:0] display_data,
  output logic                                          cs,
  output logic                                          sck,
  output logic                                          mosi,
  output logic                                          dc,
  output logic                                          vdd_c,
  output logic                                          vbat_c
);

  oled_font_pkg::char_code_t     char_code;
  oled_font_pkg::glyph_col_idx_t col_idx;
  oled_font_pkg::column_t        column;
  oled_ctrl_pkg::spi_byte_t      tx_byte;
  logic                          tx_valid, tx_ready, frame_done;

  oled_sequencer u_sequencer (
    .clk          (clk),
    .rst          (rst),
    .power_on     (power_on),
    .display_off  (display_off),
    .update       (update),
    .contrast     (contrast),
    .display_data (display_data),
    .char_code    (char_code),
    .col_idx      (col_idx),
    .column       (column),
    .tx_byte      (tx_byte),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .frame_done   (frame_done),
    .vdd_c        (vdd_c),
    .vbat_c       (vbat_c)
  );

  glyph_column u_glyph (
    .char_code (char_code),
    .col_idx   (col_idx),
    .column    (column)
  );

  spi_byte_tx u_spi (
    .clk        (clk),
    .rst        (rst),
    .tx_byte    (tx_byte),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .frame_done (frame_done),
    .cs         (cs),
    .sck        (sck),
    .mosi       (mosi),
    .dc         (dc)
  );

endmodule

// File: oled_sequencer.sv
// OLED control FSM
// Power on/off, display switching, contrast and full-screen update sequences
// feeding the SPI byte serializer

`timescale 1ns/1ps
`include "oled_defines.svh"

module oled_sequencer (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic                                            power_on,
  input  logic                                            display_off,
  input  logic                                            update,
  input  oled_ctrl_pkg::cmd_byte_t                        contrast,
  input  logic [`OLED_CHARS_PER_LINE*`OLED_LINES*8-1:0]   display_data,
  output oled_font_pkg::char_code_t                       char_code,
  output oled_font_pkg::glyph_col_idx_t                   col_idx,
  input  oled_font_pkg::column_t                          column,
  output oled_ctrl_pkg::spi_byte_t                        tx_byte,
  output logic                                            tx_valid,
  input  logic                                            tx_ready,
  input  logic                                            frame_done,
  output logic                                            vdd_c,
  output logic                                            vbat_c
);

  localparam int NCHARS = `OLED_CHARS_PER_LINE * `OLED_LINES;
  localparam int FRAME_BYTES = NCHARS * 8;
  localparam int DELAY = `OLED_POWER_DELAY;
  localparam int DLY_W = $clog2(DELAY + 1);

  oled_ctrl_pkg::seq_state_t state, state_d;
  oled_ctrl_pkg::cmd_byte_t  contrast_q;
  logic                      disp_off_q;
  logic [NCHARS*8-1:0]       data_q;
  logic [DLY_W-1:0]          delay_cnt;
  logic [8:0]                byte_cnt;  // {line, position, column}
  logic [5:0]                char_idx;
  logic                      sent_q;    // Last byte of the sequence accepted
  logic                      vdd_q, vbat_q;
  logic                      in_delay, delay_end, send_state, handshake;

  assign in_delay   = (state == oled_ctrl_pkg::PON_DELAY) || (state == oled_ctrl_pkg::POFF_DELAY);
  assign delay_end  = in_delay && (delay_cnt == DLY_W'(DELAY - 1));
  assign send_state = state inside {oled_ctrl_pkg::PON_DISPLAY_OFF, oled_ctrl_pkg::PON_INIT,
                                    oled_ctrl_pkg::CH_DISPLAY, oled_ctrl_pkg::CH_CONTRAST,
                                    oled_ctrl_pkg::UPDATE};
  assign tx_valid   = send_state && !sent_q;
  assign handshake  = tx_valid && tx_ready;

  // Character under the byte counter, character 0 in the top byte
  assign char_idx  = byte_cnt[8:3];
  assign char_code = data_q[(NCHARS - 1 - int'(char_idx)) * 8 +: 8];
  assign col_idx   = byte_cnt[2:0];

  always_comb
  begin
    state_d = state;
    case (state)
      oled_ctrl_pkg::POWER_OFF:       if (power_on) state_d = oled_ctrl_pkg::PON_DISPLAY_OFF;
      oled_ctrl_pkg::PON_DISPLAY_OFF: if (frame_done) state_d = oled_ctrl_pkg::PON_INIT;
      oled_ctrl_pkg::PON_INIT:        if (frame_done) state_d = oled_ctrl_pkg::PON_DELAY;
      oled_ctrl_pkg::PON_DELAY:       if (delay_end) state_d = oled_ctrl_pkg::DISPLAY_OFF;
      oled_ctrl_pkg::POFF_DELAY:      if (delay_end) state_d = oled_ctrl_pkg::POWER_OFF;
      oled_ctrl_pkg::IDLE:
      begin
        if (display_off || !power_on)
          state_d = oled_ctrl_pkg::CH_DISPLAY;
        else if (contrast != contrast_q)
          state_d = oled_ctrl_pkg::CH_CONTRAST;
        else if (update)
          state_d = oled_ctrl_pkg::UPDATE;
      end
      oled_ctrl_pkg::DISPLAY_OFF:
      begin
        if (!power_on)
          state_d = oled_ctrl_pkg::POFF_DELAY;
        else if (!display_off)
          state_d = oled_ctrl_pkg::CH_DISPLAY;
        else if (contrast != contrast_q)
          state_d = oled_ctrl_pkg::CH_CONTRAST;
        else if (update)
          state_d = oled_ctrl_pkg::UPDATE;
      end
      oled_ctrl_pkg::CH_DISPLAY, oled_ctrl_pkg::CH_CONTRAST, oled_ctrl_pkg::UPDATE:
      begin
        if (frame_done)
          state_d = disp_off_q ? oled_ctrl_pkg::DISPLAY_OFF : oled_ctrl_pkg::IDLE;
      end
      default: state_d = state;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state      <= oled_ctrl_pkg::POWER_OFF;
      contrast_q <= oled_ctrl_pkg::CONTRAST_RESET;
      disp_off_q <= 1'b1;
      delay_cnt  <= '0;
      byte_cnt   <= '0;
      sent_q     <= 1'b0;
      vdd_q      <= 1'b1;
      vbat_q     <= 1'b1;
    end
    else
    begin
      state <= state_d;
      if (state_d == oled_ctrl_pkg::CH_DISPLAY && state != oled_ctrl_pkg::CH_DISPLAY)
        disp_off_q <= (state == oled_ctrl_pkg::IDLE); // Off from IDLE, on from DISPLAY_OFF
      if (state_d == oled_ctrl_pkg::CH_CONTRAST && state != oled_ctrl_pkg::CH_CONTRAST)
        contrast_q <= contrast;
      delay_cnt <= in_delay ? delay_cnt + 1'b1 : '0;
      if (frame_done)
      begin
        byte_cnt <= '0;
        sent_q   <= 1'b0;
      end
      else if (handshake)
      begin
        if (tx_byte.last)
          sent_q <= 1'b1;
        else
          byte_cnt <= byte_cnt + 1'b1;
      end
      // Supply pins follow the next state, both active low
      vdd_q  <= (state_d == oled_ctrl_pkg::POWER_OFF);
      vbat_q <= state_d inside {oled_ctrl_pkg::POWER_OFF, oled_ctrl_pkg::PON_DISPLAY_OFF,
                                oled_ctrl_pkg::PON_INIT, oled_ctrl_pkg::PON_DELAY};
    end
  end

  // Screen snapshot taken when an update starts
  always_ff @(posedge clk)
  begin
    if (state_d == oled_ctrl_pkg::UPDATE && state != oled_ctrl_pkg::UPDATE)
      data_q <= display_data;
  end

  always_comb
  begin
    tx_byte = '0;
    case (state)
      oled_ctrl_pkg::PON_DISPLAY_OFF:
      begin
        tx_byte.data = oled_ctrl_pkg::CMD_DISPLAY_OFF;
        tx_byte.last = 1'b1;
      end
      oled_ctrl_pkg::PON_INIT:
      begin
        tx_byte.data = byte_cnt[0] ? oled_ctrl_pkg::ADDR_MODE_VERTICAL
                                   : oled_ctrl_pkg::CMD_SET_ADDR_MODE;
        tx_byte.last = byte_cnt[0];
      end
      oled_ctrl_pkg::CH_DISPLAY:
      begin
        tx_byte.data = disp_off_q ? oled_ctrl_pkg::CMD_DISPLAY_OFF : oled_ctrl_pkg::CMD_DISPLAY_ON;
        tx_byte.last = 1'b1;
      end
      oled_ctrl_pkg::CH_CONTRAST:
      begin
        tx_byte.data = byte_cnt[0] ? contrast_q : oled_ctrl_pkg::CMD_SET_CONTRAST;
        tx_byte.last = byte_cnt[0];
      end
      oled_ctrl_pkg::UPDATE:
      begin
        tx_byte.data = column;
        tx_byte.dc   = 1'b1;
        tx_byte.last = (byte_cnt == 9'(FRAME_BYTES - 1));
      end
      default: tx_byte = '0;
    endcase
  end

  assign vdd_c  = vdd_q;
  assign vbat_c = vbat_q;

endmodule

// File: spi_byte_tx.sv
// Write-only SPI byte serializer for the OLED
// SCK divider, one-byte holding buffer, shift register and CS framing

`timescale 1ns/1ps
`include "oled_defines.svh"

module spi_byte_tx (
  input  logic                     clk,
  input  logic                     rst,
  input  oled_ctrl_pkg::spi_byte_t tx_byte,
  input  logic                     tx_valid,
  output logic                     tx_ready,
  output logic                     frame_done,
  output logic                     cs,
  output logic                     sck,
  output logic                     mosi,
  output logic                     dc
);

  localparam int HALF = `OLED_SCK_HALF;
  localparam int DIV_W = $clog2(HALF + 1);

  oled_ctrl_pkg::spi_byte_t hold_q;
  logic                     hold_valid;
  logic [DIV_W-1:0]         div_cnt;
  logic [7:0]               shift_q;
  logic [2:0]               bit_cnt;
  logic                     have_byte;  // Shift register busy
  logic                     last_q, dc_q, cs_q, sck_q, done_q;
  logic                     tick, load, close;

  assign tick  = !cs_q && (div_cnt == DIV_W'(HALF - 1)); // SCK edge point
  assign load  = tick && sck_q && !have_byte && !last_q && hold_valid;
  assign close = tick && sck_q && !have_byte && last_q;

  assign tx_ready = !hold_valid;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      hold_valid <= 1'b0;
    else if (tx_valid && tx_ready)
      hold_valid <= 1'b1;
    else if (load)
      hold_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (tx_valid && tx_ready)
      hold_q <= tx_byte;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      div_cnt <= '0;
    else if (cs_q || tick)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      cs_q      <= 1'b1;
      sck_q     <= 1'b1;
      have_byte <= 1'b0;
      last_q    <= 1'b0;
      bit_cnt   <= '0;
      shift_q   <= '0;
      dc_q      <= 1'b0;
      done_q    <= 1'b0;
    end
    else
    begin
      done_q <= close;
      if (cs_q)
      begin
        if (hold_valid)
          cs_q <= 1'b0; // Lead-in of one half-period follows
      end
      else if (tick && !sck_q)
      begin
        sck_q   <= 1'b1; // Rising edge, receiver samples
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == 3'd7)
          have_byte <= 1'b0;
      end
      else if (tick && have_byte)
      begin
        sck_q   <= 1'b0;
        shift_q <= {shift_q[6:0], 1'b0};
      end
      else if (close)
      begin
        cs_q   <= 1'b1;
        last_q <= 1'b0;
      end
      else if (load)
      begin
        sck_q     <= 1'b0;
        have_byte <= 1'b1;
        shift_q   <= hold_q.data;
        dc_q      <= hold_q.dc;
        last_q    <= hold_q.last;
      end
    end
  end

  assign cs         = cs_q;
  assign sck        = sck_q;
  assign mosi       = shift_q[7]; // MSB first
  assign dc         = dc_q;
  assign frame_done = done_q;

endmodule

// File: glyph_column.sv
// Reduced 8x8 font lookup and column extraction
// Space, digits and A-F, all other codes blank

`timescale 1ns/1ps

module glyph_column (
  input  oled_font_pkg::char_code_t     char_code,
  input  oled_font_pkg::glyph_col_idx_t col_idx,
  output oled_font_pkg::column_t        column
);

  oled_font_pkg::glyph_t glyph;

  always_comb
  begin
    case (char_code)
      8'h10:   glyph = 64'h3c42_6252_4a46_423c; // 0
      8'h11:   glyph = 64'h1828_0808_0808_083e;
      8'h12:   glyph = 64'h3c42_0204_0810_207e;
      8'h13:   glyph = 64'h3c42_0206_3c06_423c;
      8'h14:   glyph = 64'h040c_1424_447e_0404;
      8'h15:   glyph = 64'h7e40_407c_0202_027c;
      8'h16:   glyph = 64'h3c42_405c_6242_423c;
      8'h17:   glyph = 64'h7e02_0204_0810_2040;
      8'h18:   glyph = 64'h3c42_4242_3c42_423c;
      8'h19:   glyph = 64'h3c42_4246_3a02_423c; // 9
      8'h21:   glyph = 64'h1824_427e_4242_e700; // A
      8'h22:   glyph = 64'h7844_4478_4444_7800;
      8'h23:   glyph = 64'h3c42_4040_4042_3c00;
      8'h24:   glyph = 64'h7c42_4242_4242_7c00;
      8'h25:   glyph = 64'h7c40_407c_4040_7c00;
      8'h26:   glyph = 64'h7c40_407c_4040_4000; // F
      default: glyph = '0;                      // Space and unsupported codes
    endcase
  end

  // Row k of the glyph goes to bit k of the column byte
  always_comb
  begin
    for (int k = 0; k < 8; k++)
      column[k] = glyph[63 - 8 * k - int'(col_idx)];
  end

endmodule

// File: oled_font_pkg.sv
// Font types for the character path
// Character codes, 8x8 glyphs and column bytes

package oled_font_pkg;

  typedef logic [7:0] char_code_t;

  // Row 0 in the top byte, pixel 0 of a row in its MSB
  typedef logic [63:0] glyph_t;

  // Bit k holds row k
  typedef logic [7:0] column_t;

  // Column number, 0 at the left
  typedef logic [2:0] glyph_col_idx_t;

endpackage

// File: oled_ctrl_pkg.sv
// Control types for the OLED driver
// Sequencer states, SSD1306 command bytes and the serializer byte struct

package oled_ctrl_pkg;

  typedef enum logic [3:0] {
    POWER_OFF,
    PON_DISPLAY_OFF,
    PON_INIT,
    PON_DELAY,
    DISPLAY_OFF,
    IDLE,
    CH_DISPLAY,
    CH_CONTRAST,
    UPDATE,
    POFF_DELAY
  } seq_state_t;

  typedef logic [7:0] cmd_byte_t;

  // SSD1306 commands in use
  localparam cmd_byte_t CMD_DISPLAY_ON     = 8'hAF;
  localparam cmd_byte_t CMD_DISPLAY_OFF    = 8'hAE;
  localparam cmd_byte_t CMD_SET_CONTRAST   = 8'h81;
  localparam cmd_byte_t CMD_SET_ADDR_MODE  = 8'h20;
  localparam cmd_byte_t ADDR_MODE_VERTICAL = 8'h01; // Argument of CMD_SET_ADDR_MODE
  localparam cmd_byte_t CONTRAST_RESET     = 8'h7F;

  // One byte handed to the serializer
  typedef struct packed {
    cmd_byte_t data;
    logic      dc;   // High for display data
    logic      last; // Closes the CS frame
  } spi_byte_t;

endpackage

// File: oled_defines.svh
// Timing and geometry constants for the OLED text display
// SCK divider, power sequence wait and character grid size

`ifndef OLED_DEFINES_SVH
`define OLED_DEFINES_SVH

// clk cycles per SCK half-period
`define OLED_SCK_HALF 2

// Power sequence wait in clk cycles, short value for simulation
// 100 ms at the board clock goes here for hardware
`define OLED_POWER_DELAY 64

// Text grid
`define OLED_CHARS_PER_LINE 16
`define OLED_LINES 4

`endif
